// ==== bench/cbus_chk.sv ====
/*
 * Concurrent assertions on the completion bus, bound into the top level.
 * Covers pipe0 source exclusivity, flush kill and pipe0 payload hold.
 */
`default_nettype none

module cbus_chk import cbus_types_pkg::*; (
  input logic         inst_vld_clk,
  input logic         cpurst_b,
  input logic         rtu_yy_xx_flush,
  input logic         idu_iu_rf_pipe0_sel,
  input logic         idu_iu_rf_div_sel,
  input logic         special_cbus_ex1_inst_vld,
  input logic         cp0_iu_ex3_inst_vld,
  input logic         pipe0_cmplt,
  input pipe0_cmplt_t pipe0_data,
  input logic         iu_rtu_pipe0_cmplt,
  input logic         iu_rtu_pipe1_cmplt
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  // At most one pipe0 source per cycle
  src_onehot: assert property (
    @(posedge inst_vld_clk) disable iff (!cpurst_b)
    $onehot0({idu_iu_rf_pipe0_sel, idu_iu_rf_div_sel,
              special_cbus_ex1_inst_vld, cp0_iu_ex3_inst_vld})
  ) else begin
    fail_cnt++;
    $error("more than one pipe0 completion source is valid");
  end

  // Flush kills both completion valids
  flush_kill: assert property (
    @(posedge inst_vld_clk) disable iff (!cpurst_b)
    rtu_yy_xx_flush |=> !iu_rtu_pipe0_cmplt && !iu_rtu_pipe1_cmplt
  ) else begin
    fail_cnt++;
    $error("completion valid seen in the cycle after a flush");
  end

  data_hold: assert property (
    @(posedge inst_vld_clk) disable iff (!cpurst_b)
    !pipe0_cmplt |=> $stable(pipe0_data)
  ) else begin
    fail_cnt++;
    $error("pipe0 payload changed without a completion strobe");
  end

endmodule

bind cbus_top cbus_chk i_cbus_chk (
  .inst_vld_clk              (inst_vld_clk),
  .cpurst_b                  (cpurst_b),
  .rtu_yy_xx_flush           (rtu_yy_xx_flush),
  .idu_iu_rf_pipe0_sel       (idu_iu_rf_pipe0_sel),
  .idu_iu_rf_div_sel         (idu_iu_rf_div_sel),
  .special_cbus_ex1_inst_vld (special_cbus_ex1_inst_vld),
  .cp0_iu_ex3_inst_vld       (cp0_iu_ex3_inst_vld),
  .pipe0_cmplt               (pipe0_cmplt),
  .pipe0_data                (pipe0_data),
  .iu_rtu_pipe0_cmplt        (iu_rtu_pipe0_cmplt),
  .iu_rtu_pipe1_cmplt        (iu_rtu_pipe1_cmplt)
);

`default_nettype wire

// ==== bench/cbus_tb.sv ====
/*
 * Random testbench for the completion bus. A cycle model predicts every
 * retire-side output from the sampled inputs; outputs are compared at
 * the falling edge, where registered and pass-through values are stable.
 */
`default_nettype none

module cbus_tb import cbus_cfg_pkg::*, cbus_types_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF    = 20;
  localparam int DRV_DLY     = 2;
  localparam int RST_CYCLES  = 10;
  localparam int STIM_CYCLES = 1800;
  // Reset, stimulus and drain, with slack on top
  localparam int MAX_CYCLES  = RST_CYCLES + STIM_CYCLES + 190;

  logic                  inst_vld_clk;
  logic                  cpurst_b;
  logic                  rtu_yy_xx_flush;
  logic                  idu_iu_rf_pipe0_sel;
  logic                  idu_iu_rf_div_sel;
  logic [IID_W-1:0]      idu_iu_rf_pipe0_iid;
  logic                  idu_iu_rf_pipe1_sel;
  logic                  idu_iu_rf_mult_sel;
  logic [IID_W-1:0]      idu_iu_rf_pipe1_iid;
  logic                  special_cbus_ex1_inst_vld;
  logic [IID_W-1:0]      special_cbus_ex1_iid;
  logic                  special_cbus_ex1_abnormal;
  logic                  special_cbus_ex1_expt_vld;
  logic [EXPT_VEC_W-1:0] special_cbus_ex1_expt_vec;
  logic                  special_cbus_ex1_flush;
  logic                  special_cbus_ex1_bkpt;
  logic [MTVAL_W-1:0]    special_cbus_ex1_mtval;
  logic                  cp0_iu_ex3_inst_vld;
  logic [IID_W-1:0]      cp0_iu_ex3_iid;
  logic                  cp0_iu_ex3_abnormal;
  logic                  cp0_iu_ex3_expt_vld;
  logic [EXPT_VEC_W-1:0] cp0_iu_ex3_expt_vec;
  logic                  cp0_iu_ex3_flush;
  logic [MTVAL_W-1:0]    cp0_iu_ex3_mtval;
  logic                  cp0_iu_ex3_efpc_vld;
  logic [EFPC_W-1:0]     cp0_iu_ex3_efpc;
  logic                  bju_cbus_ex2_pipe2_sel;
  logic [IID_W-1:0]      bju_cbus_ex2_pipe2_iid;
  logic                  bju_cbus_ex2_pipe2_abnormal;
  logic                  bju_cbus_ex2_pipe2_jmp_mispred;
  logic                  bju_cbus_ex2_pipe2_bht_mispred;
  logic                  iu_rtu_pipe0_cmplt;
  logic [IID_W-1:0]      iu_rtu_pipe0_iid;
  logic                  iu_rtu_pipe0_abnormal;
  logic                  iu_rtu_pipe0_expt_vld;
  logic [EXPT_VEC_W-1:0] iu_rtu_pipe0_expt_vec;
  logic                  iu_rtu_pipe0_flush;
  logic                  iu_rtu_pipe0_bkpt;
  logic [MTVAL_W-1:0]    iu_rtu_pipe0_mtval;
  logic                  iu_rtu_pipe0_efpc_vld;
  logic [EFPC_W-1:0]     iu_rtu_pipe0_efpc;
  logic                  iu_rtu_pipe1_cmplt;
  logic [IID_W-1:0]      iu_rtu_pipe1_iid;
  logic                  iu_rtu_pipe2_cmplt;
  logic [IID_W-1:0]      iu_rtu_pipe2_iid;
  logic                  iu_rtu_pipe2_abnormal;
  logic                  iu_rtu_pipe2_jmp_mispred;
  logic                  iu_rtu_pipe2_bht_mispred;

  // Model state
  logic         exp_p0_cmplt;
  pipe0_cmplt_t exp_p0;
  logic         exp_p1_cmplt;
  iid_t         exp_p1_iid;

  integer seed;
  string  test_name;
  int     cycle_cnt    = 0;
  int     mismatch_cnt = 0;
  int     other_cnt    = 0;
  int     hit_idu      = 0;
  int     hit_spc      = 0;
  int     hit_cp0      = 0;
  int     hit_p1       = 0;
  int     hit_flush    = 0;

  cbus_top i_cbus_top (.*);

  always #CLK_HALF inst_vld_clk = ~inst_vld_clk;

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic clear_strobes();
    idu_iu_rf_pipe0_sel       = 1'b0;
    idu_iu_rf_div_sel         = 1'b0;
    idu_iu_rf_pipe1_sel       = 1'b0;
    idu_iu_rf_mult_sel        = 1'b0;
    special_cbus_ex1_inst_vld = 1'b0;
    cp0_iu_ex3_inst_vld       = 1'b0;
    rtu_yy_xx_flush           = 1'b0;
    bju_cbus_ex2_pipe2_sel    = 1'b0;
  endtask

  task automatic clear_inputs();
    clear_strobes();
    idu_iu_rf_pipe0_iid            = '0;
    idu_iu_rf_pipe1_iid            = '0;
    special_cbus_ex1_iid           = '0;
    special_cbus_ex1_abnormal      = 1'b0;
    special_cbus_ex1_expt_vld      = 1'b0;
    special_cbus_ex1_expt_vec      = '0;
    special_cbus_ex1_flush         = 1'b0;
    special_cbus_ex1_bkpt          = 1'b0;
    special_cbus_ex1_mtval         = '0;
    cp0_iu_ex3_iid                 = '0;
    cp0_iu_ex3_abnormal            = 1'b0;
    cp0_iu_ex3_expt_vld            = 1'b0;
    cp0_iu_ex3_expt_vec            = '0;
    cp0_iu_ex3_flush               = 1'b0;
    cp0_iu_ex3_mtval               = '0;
    cp0_iu_ex3_efpc_vld            = 1'b0;
    cp0_iu_ex3_efpc                = '0;
    bju_cbus_ex2_pipe2_iid         = '0;
    bju_cbus_ex2_pipe2_abnormal    = 1'b0;
    bju_cbus_ex2_pipe2_jmp_mispred = 1'b0;
    bju_cbus_ex2_pipe2_bht_mispred = 1'b0;
  endtask

  // Data of idle sources is random too, so the zero rules get exercised
  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] r_hi;
    r = $random(seed);
    clear_strobes();
    case (r[2:0])
      3'd0:    idu_iu_rf_pipe0_sel = 1'b1;
      3'd1:    idu_iu_rf_div_sel = 1'b1;
      3'd2:    special_cbus_ex1_inst_vld = 1'b1;
      3'd3:    cp0_iu_ex3_inst_vld = 1'b1;
      default: ;
    endcase
    idu_iu_rf_pipe1_sel            = r[3];
    idu_iu_rf_mult_sel             = r[4];
    // Roughly one flush in eight cycles
    rtu_yy_xx_flush                = (r[7:5] == 3'd0);
    bju_cbus_ex2_pipe2_sel         = r[8];
    bju_cbus_ex2_pipe2_abnormal    = r[9];
    bju_cbus_ex2_pipe2_jmp_mispred = r[10];
    bju_cbus_ex2_pipe2_bht_mispred = r[11];
    special_cbus_ex1_abnormal      = r[12];
    special_cbus_ex1_expt_vld      = r[13];
    special_cbus_ex1_flush         = r[14];
    special_cbus_ex1_bkpt          = r[15];
    cp0_iu_ex3_abnormal            = r[16];
    cp0_iu_ex3_expt_vld            = r[17];
    cp0_iu_ex3_flush               = r[18];
    cp0_iu_ex3_efpc_vld            = r[19];
    special_cbus_ex1_expt_vec      = r[24:20];
    cp0_iu_ex3_expt_vec            = r[29:25];
    r = $random(seed);
    idu_iu_rf_pipe0_iid            = r[6:0];
    idu_iu_rf_pipe1_iid            = r[13:7];
    special_cbus_ex1_iid           = r[20:14];
    cp0_iu_ex3_iid                 = r[27:21];
    r = $random(seed);
    bju_cbus_ex2_pipe2_iid         = r[6:0];
    special_cbus_ex1_mtval         = $random(seed);
    cp0_iu_ex3_mtval               = $random(seed);
    r_hi = $random(seed);
    cp0_iu_ex3_efpc                = {r[13:7], r_hi};
  endtask

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  task automatic predict();
    logic         p0_vld;
    logic         p1_vld;
    pipe0_cmplt_t nxt;
    nxt    = '0;
    p0_vld = 1'b1;
    // Each source fills only the fields it carries
    if (idu_iu_rf_pipe0_sel || idu_iu_rf_div_sel) begin
      nxt.iid = idu_iu_rf_pipe0_iid;
      hit_idu++;
    end else if (special_cbus_ex1_inst_vld) begin
      nxt.iid      = special_cbus_ex1_iid;
      nxt.abnormal = special_cbus_ex1_abnormal;
      nxt.expt_vld = special_cbus_ex1_expt_vld;
      nxt.expt_vec = special_cbus_ex1_expt_vec;
      nxt.flush    = special_cbus_ex1_flush;
      nxt.bkpt     = special_cbus_ex1_bkpt;
      nxt.mtval    = special_cbus_ex1_mtval;
      hit_spc++;
    end else if (cp0_iu_ex3_inst_vld) begin
      nxt.iid      = cp0_iu_ex3_iid;
      nxt.abnormal = cp0_iu_ex3_abnormal;
      nxt.expt_vld = cp0_iu_ex3_expt_vld;
      nxt.expt_vec = cp0_iu_ex3_expt_vec;
      nxt.flush    = cp0_iu_ex3_flush;
      nxt.mtval    = cp0_iu_ex3_mtval;
      nxt.efpc_vld = cp0_iu_ex3_efpc_vld;
      nxt.efpc     = cp0_iu_ex3_efpc;
      hit_cp0++;
    end else begin
      p0_vld = 1'b0;
    end
    p1_vld = idu_iu_rf_pipe1_sel || idu_iu_rf_mult_sel;
    if (p1_vld) begin
      hit_p1++;
    end
    if (rtu_yy_xx_flush && (p0_vld || p1_vld)) begin
      hit_flush++;
    end

    exp_p0_cmplt = p0_vld && !rtu_yy_xx_flush;
    exp_p1_cmplt = p1_vld && !rtu_yy_xx_flush;
    if (p0_vld) begin
      exp_p0 = nxt;
    end
    if (p1_vld) begin
      exp_p1_iid = idu_iu_rf_pipe1_iid;
    end
  endtask

  always @(posedge inst_vld_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      exp_p0_cmplt = 1'b0;
      exp_p0       = '0;
      exp_p1_cmplt = 1'b0;
      exp_p1_iid   = '0;
    end else begin
      predict();
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  task automatic check_field(input string field, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    assert (act_v === exp_v) else begin
      mismatch_cnt++;
      $display("mismatch %s %s: expected %0h, actual %0h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic check_outputs();
    check_field("pipe0_cmplt", 64'(exp_p0_cmplt), 64'(iu_rtu_pipe0_cmplt));
    check_field("pipe0_iid", 64'(exp_p0.iid), 64'(iu_rtu_pipe0_iid));
    check_field("pipe0_abnormal", 64'(exp_p0.abnormal), 64'(iu_rtu_pipe0_abnormal));
    check_field("pipe0_expt_vld", 64'(exp_p0.expt_vld), 64'(iu_rtu_pipe0_expt_vld));
    check_field("pipe0_expt_vec", 64'(exp_p0.expt_vec), 64'(iu_rtu_pipe0_expt_vec));
    check_field("pipe0_flush", 64'(exp_p0.flush), 64'(iu_rtu_pipe0_flush));
    check_field("pipe0_bkpt", 64'(exp_p0.bkpt), 64'(iu_rtu_pipe0_bkpt));
    check_field("pipe0_mtval", 64'(exp_p0.mtval), 64'(iu_rtu_pipe0_mtval));
    check_field("pipe0_efpc_vld", 64'(exp_p0.efpc_vld), 64'(iu_rtu_pipe0_efpc_vld));
    check_field("pipe0_efpc", 64'(exp_p0.efpc), 64'(iu_rtu_pipe0_efpc));
    check_field("pipe1_cmplt", 64'(exp_p1_cmplt), 64'(iu_rtu_pipe1_cmplt));
    check_field("pipe1_iid", 64'(exp_p1_iid), 64'(iu_rtu_pipe1_iid));
    // Pipe2 is a plain rename of the branch unit report
    check_field("pipe2_cmplt", 64'(bju_cbus_ex2_pipe2_sel), 64'(iu_rtu_pipe2_cmplt));
    check_field("pipe2_iid", 64'(bju_cbus_ex2_pipe2_iid), 64'(iu_rtu_pipe2_iid));
    check_field("pipe2_abnormal", 64'(bju_cbus_ex2_pipe2_abnormal),
                64'(iu_rtu_pipe2_abnormal));
    check_field("pipe2_jmp_mispred", 64'(bju_cbus_ex2_pipe2_jmp_mispred),
                64'(iu_rtu_pipe2_jmp_mispred));
    check_field("pipe2_bht_mispred", 64'(bju_cbus_ex2_pipe2_bht_mispred),
                64'(iu_rtu_pipe2_bht_mispred));
  endtask

  task automatic check_coverage();
    assert (hit_idu > 0 && hit_spc > 0 && hit_cp0 > 0 && hit_p1 > 0 && hit_flush > 0)
    else begin
      other_cnt++;
      $display("stimulus did not reach every completion source and a flush");
    end
  endtask

  task automatic end_run();
    other_cnt += i_cbus_top.i_cbus_chk.fail_cnt;
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  always @(negedge inst_vld_clk) begin
    if (cycle_cnt > 0) begin
      check_outputs();
    end
  end

  always @(posedge inst_vld_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      other_cnt++;
      $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
      end_run();
    end
  end

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    seed         = 79931;
    inst_vld_clk = 1'b0;
    cpurst_b     = 1'b0;
    test_name    = "reset";
    clear_inputs();
    repeat (RST_CYCLES) @(posedge inst_vld_clk);
    #DRV_DLY;
    cpurst_b  = 1'b1;
    test_name = "random";
    repeat (STIM_CYCLES) begin
      @(posedge inst_vld_clk);
      #DRV_DLY;
      drive_random();
    end
    // Quiet cycles so the data outputs must hold
    @(posedge inst_vld_clk);
    #DRV_DLY;
    test_name = "drain";
    clear_strobes();
    repeat (4) @(posedge inst_vld_clk);
    @(negedge inst_vld_clk);
    #1;
    check_coverage();
    end_run();
  end

endmodule

`default_nettype wire

// ==== design/cbus_cfg_pkg.sv ====
/*
 * Field widths of the integer unit completion bus.
 * Imported by the type package, the source interface and the top level.
 */
`default_nettype none

package cbus_cfg_pkg;

  // Instruction id from the reorder buffer
  localparam int IID_W      = 7;

  // Exception vector
  localparam int EXPT_VEC_W = 5;

  // Trap value reported with an exception
  localparam int MTVAL_W    = 32;

  // Exception PC from the system-register unit
  localparam int EFPC_W     = 39;

endpackage

`default_nettype wire

// ==== design/cbus_cmplt_stage.sv ====
/*
 * One completion register. The valid flop follows the strobe and is
 * killed by a global flush; the payload loads on a strobe and holds
 * otherwise. Used for pipe0 with the full record and pipe1 with an iid.
 */
`default_nettype none

module cbus_cmplt_stage import cbus_types_pkg::*; #(
  parameter type payload_t = iid_t
) (
  input  logic     inst_vld_clk,
  input  logic     cpurst_b,
  input  logic     flush,
  input  logic     cmplt,
  input  payload_t src,
  output logic     vld,
  output payload_t data
);

  // ------------------------------------------------------------------------
  // Completion valid
  // ------------------------------------------------------------------------
  always_ff @(posedge inst_vld_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      vld <= 1'b0;
    end else if (flush) begin
      vld <= 1'b0;
    end else begin
      vld <= cmplt;
    end
  end

  // ------------------------------------------------------------------------
  // Completion payload
  // ------------------------------------------------------------------------
  // Flush leaves the payload alone since the valid already hides it
  always_ff @(posedge inst_vld_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      data <= '0;
    end else if (cmplt) begin
      data <= src;
    end
  end

endmodule

`default_nettype wire

// ==== design/cbus_pipe0_src_sel.sv ====
/*
 * Pipe0 source merge. At most one source is valid per cycle, so each
 * record field is an AND-OR of the sources that carry it.
 */
`default_nettype none

module cbus_pipe0_src_sel import cbus_cfg_pkg::*, cbus_types_pkg::*; (
  cbus_src_if.sel src,
  output logic         cmplt,
  output pipe0_cmplt_t rec
);

  logic idu_vld;
  logic spc_vld;
  logic cp0_vld;

  // ------------------------------------------------------------------------
  // Completion strobe
  // ------------------------------------------------------------------------
  // ALU and divide issue share the pipe0 iid
  assign idu_vld = src.idu_pipe0_sel | src.idu_div_sel;
  assign spc_vld = src.special_inst_vld;
  assign cp0_vld = src.cp0_inst_vld;

  assign cmplt = idu_vld | spc_vld | cp0_vld;

  // ------------------------------------------------------------------------
  // Record select
  // ------------------------------------------------------------------------
  always_comb begin
    rec.iid      = {IID_W{idu_vld}} & src.idu_pipe0_iid
                 | {IID_W{spc_vld}} & src.special_iid
                 | {IID_W{cp0_vld}} & src.cp0_iid;

    // Issue path reports no exception state
    rec.abnormal = spc_vld & src.special_abnormal
                 | cp0_vld & src.cp0_abnormal;

    rec.expt_vld = spc_vld & src.special_expt_vld
                 | cp0_vld & src.cp0_expt_vld;

    rec.expt_vec = {EXPT_VEC_W{spc_vld}} & src.special_expt_vec
                 | {EXPT_VEC_W{cp0_vld}} & src.cp0_expt_vec;

    rec.flush    = spc_vld & src.special_flush
                 | cp0_vld & src.cp0_flush;

    rec.bkpt     = spc_vld & src.special_bkpt;

    rec.mtval    = {MTVAL_W{spc_vld}} & src.special_mtval
                 | {MTVAL_W{cp0_vld}} & src.cp0_mtval;

    // Exception PC only comes from the system-register unit
    rec.efpc_vld = cp0_vld & src.cp0_efpc_vld;
    rec.efpc     = {EFPC_W{cp0_vld}} & src.cp0_efpc;
  end

endmodule

`default_nettype wire

// ==== design/cbus_src_if.sv ====
/*
 * Bundle of the three pipe0 completion sources.
 * The top level drives it from its ports, the source select reads it.
 */
`default_nettype none

interface cbus_src_if import cbus_cfg_pkg::*, cbus_types_pkg::*; ();

  // Issue of an ALU or divide instruction
  logic                  idu_pipe0_sel;
  logic                  idu_div_sel;
  iid_t                  idu_pipe0_iid;

  // Special-instruction unit
  logic                  special_inst_vld;
  iid_t                  special_iid;
  logic                  special_abnormal;
  logic                  special_expt_vld;
  logic [EXPT_VEC_W-1:0] special_expt_vec;
  logic                  special_flush;
  logic                  special_bkpt;
  logic [MTVAL_W-1:0]    special_mtval;

  // System-register unit
  logic                  cp0_inst_vld;
  iid_t                  cp0_iid;
  logic                  cp0_abnormal;
  logic                  cp0_expt_vld;
  logic [EXPT_VEC_W-1:0] cp0_expt_vec;
  logic                  cp0_flush;
  logic [MTVAL_W-1:0]    cp0_mtval;
  logic                  cp0_efpc_vld;
  logic [EFPC_W-1:0]     cp0_efpc;

  modport drv (
    output idu_pipe0_sel, idu_div_sel, idu_pipe0_iid,
    output special_inst_vld, special_iid, special_abnormal, special_expt_vld,
    output special_expt_vec, special_flush, special_bkpt, special_mtval,
    output cp0_inst_vld, cp0_iid, cp0_abnormal, cp0_expt_vld, cp0_expt_vec,
    output cp0_flush, cp0_mtval, cp0_efpc_vld, cp0_efpc
  );

  modport sel (
    input idu_pipe0_sel, idu_div_sel, idu_pipe0_iid,
    input special_inst_vld, special_iid, special_abnormal, special_expt_vld,
    input special_expt_vec, special_flush, special_bkpt, special_mtval,
    input cp0_inst_vld, cp0_iid, cp0_abnormal, cp0_expt_vld, cp0_expt_vec,
    input cp0_flush, cp0_mtval, cp0_efpc_vld, cp0_efpc
  );

endinterface

`default_nettype wire

// ==== design/cbus_top.sv ====
/*
 * Completion bus of the integer unit. Registers pipe0 and pipe1
 * completions for the retire unit and renames the already registered
 * pipe2 report from the branch unit.
 */
`default_nettype none

module cbus_top import cbus_cfg_pkg::*, cbus_types_pkg::*; (
  input  logic                  inst_vld_clk,
  input  logic                  cpurst_b,
  input  logic                  rtu_yy_xx_flush,
  // Issue
  input  logic                  idu_iu_rf_pipe0_sel,
  input  logic                  idu_iu_rf_div_sel,
  input  logic [IID_W-1:0]      idu_iu_rf_pipe0_iid,
  input  logic                  idu_iu_rf_pipe1_sel,
  input  logic                  idu_iu_rf_mult_sel,
  input  logic [IID_W-1:0]      idu_iu_rf_pipe1_iid,
  // Special-instruction unit
  input  logic                  special_cbus_ex1_inst_vld,
  input  logic [IID_W-1:0]      special_cbus_ex1_iid,
  input  logic                  special_cbus_ex1_abnormal,
  input  logic                  special_cbus_ex1_expt_vld,
  input  logic [EXPT_VEC_W-1:0] special_cbus_ex1_expt_vec,
  input  logic                  special_cbus_ex1_flush,
  input  logic                  special_cbus_ex1_bkpt,
  input  logic [MTVAL_W-1:0]    special_cbus_ex1_mtval,
  // System-register unit
  input  logic                  cp0_iu_ex3_inst_vld,
  input  logic [IID_W-1:0]      cp0_iu_ex3_iid,
  input  logic                  cp0_iu_ex3_abnormal,
  input  logic                  cp0_iu_ex3_expt_vld,
  input  logic [EXPT_VEC_W-1:0] cp0_iu_ex3_expt_vec,
  input  logic                  cp0_iu_ex3_flush,
  input  logic [MTVAL_W-1:0]    cp0_iu_ex3_mtval,
  input  logic                  cp0_iu_ex3_efpc_vld,
  input  logic [EFPC_W-1:0]     cp0_iu_ex3_efpc,
  // Branch unit
  input  logic                  bju_cbus_ex2_pipe2_sel,
  input  logic [IID_W-1:0]      bju_cbus_ex2_pipe2_iid,
  input  logic                  bju_cbus_ex2_pipe2_abnormal,
  input  logic                  bju_cbus_ex2_pipe2_jmp_mispred,
  input  logic                  bju_cbus_ex2_pipe2_bht_mispred,
  // To retire unit
  output logic                  iu_rtu_pipe0_cmplt,
  output logic [IID_W-1:0]      iu_rtu_pipe0_iid,
  output logic                  iu_rtu_pipe0_abnormal,
  output logic                  iu_rtu_pipe0_expt_vld,
  output logic [EXPT_VEC_W-1:0] iu_rtu_pipe0_expt_vec,
  output logic                  iu_rtu_pipe0_flush,
  output logic                  iu_rtu_pipe0_bkpt,
  output logic [MTVAL_W-1:0]    iu_rtu_pipe0_mtval,
  output logic                  iu_rtu_pipe0_efpc_vld,
  output logic [EFPC_W-1:0]     iu_rtu_pipe0_efpc,
  output logic                  iu_rtu_pipe1_cmplt,
  output logic [IID_W-1:0]      iu_rtu_pipe1_iid,
  output logic                  iu_rtu_pipe2_cmplt,
  output logic [IID_W-1:0]      iu_rtu_pipe2_iid,
  output logic                  iu_rtu_pipe2_abnormal,
  output logic                  iu_rtu_pipe2_jmp_mispred,
  output logic                  iu_rtu_pipe2_bht_mispred
);

  logic         pipe0_cmplt;
  pipe0_cmplt_t pipe0_rec;
  pipe0_cmplt_t pipe0_data;
  logic         pipe1_cmplt;

  cbus_src_if i_src_if ();

  // ------------------------------------------------------------------------
  // Pipe0
  // ------------------------------------------------------------------------
  assign i_src_if.idu_pipe0_sel    = idu_iu_rf_pipe0_sel;
  assign i_src_if.idu_div_sel      = idu_iu_rf_div_sel;
  assign i_src_if.idu_pipe0_iid    = idu_iu_rf_pipe0_iid;

  assign i_src_if.special_inst_vld = special_cbus_ex1_inst_vld;
  assign i_src_if.special_iid      = special_cbus_ex1_iid;
  assign i_src_if.special_abnormal = special_cbus_ex1_abnormal;
  assign i_src_if.special_expt_vld = special_cbus_ex1_expt_vld;
  assign i_src_if.special_expt_vec = special_cbus_ex1_expt_vec;
  assign i_src_if.special_flush    = special_cbus_ex1_flush;
  assign i_src_if.special_bkpt     = special_cbus_ex1_bkpt;
  assign i_src_if.special_mtval    = special_cbus_ex1_mtval;

  assign i_src_if.cp0_inst_vld     = cp0_iu_ex3_inst_vld;
  assign i_src_if.cp0_iid          = cp0_iu_ex3_iid;
  assign i_src_if.cp0_abnormal     = cp0_iu_ex3_abnormal;
  assign i_src_if.cp0_expt_vld     = cp0_iu_ex3_expt_vld;
  assign i_src_if.cp0_expt_vec     = cp0_iu_ex3_expt_vec;
  assign i_src_if.cp0_flush        = cp0_iu_ex3_flush;
  assign i_src_if.cp0_mtval        = cp0_iu_ex3_mtval;
  assign i_src_if.cp0_efpc_vld     = cp0_iu_ex3_efpc_vld;
  assign i_src_if.cp0_efpc         = cp0_iu_ex3_efpc;

  cbus_pipe0_src_sel i_pipe0_src_sel (
    .src   (i_src_if.sel),
    .cmplt (pipe0_cmplt),
    .rec   (pipe0_rec)
  );

  cbus_cmplt_stage #(
    .payload_t (pipe0_cmplt_t)
  ) i_pipe0_stage (
    .inst_vld_clk (inst_vld_clk),
    .cpurst_b     (cpurst_b),
    .flush        (rtu_yy_xx_flush),
    .cmplt        (pipe0_cmplt),
    .src          (pipe0_rec),
    .vld          (iu_rtu_pipe0_cmplt),
    .data         (pipe0_data)
  );

  assign iu_rtu_pipe0_iid      = pipe0_data.iid;
  assign iu_rtu_pipe0_abnormal = pipe0_data.abnormal;
  assign iu_rtu_pipe0_expt_vld = pipe0_data.expt_vld;
  assign iu_rtu_pipe0_expt_vec = pipe0_data.expt_vec;
  assign iu_rtu_pipe0_flush    = pipe0_data.flush;
  assign iu_rtu_pipe0_bkpt     = pipe0_data.bkpt;
  assign iu_rtu_pipe0_mtval    = pipe0_data.mtval;
  assign iu_rtu_pipe0_efpc_vld = pipe0_data.efpc_vld;
  assign iu_rtu_pipe0_efpc     = pipe0_data.efpc;

  // ------------------------------------------------------------------------
  // Pipe1
  // ------------------------------------------------------------------------
  // ALU and multiply issue share one iid
  assign pipe1_cmplt = idu_iu_rf_pipe1_sel | idu_iu_rf_mult_sel;

  cbus_cmplt_stage #(
    .payload_t (iid_t)
  ) i_pipe1_stage (
    .inst_vld_clk (inst_vld_clk),
    .cpurst_b     (cpurst_b),
    .flush        (rtu_yy_xx_flush),
    .cmplt        (pipe1_cmplt),
    .src          (idu_iu_rf_pipe1_iid),
    .vld          (iu_rtu_pipe1_cmplt),
    .data         (iu_rtu_pipe1_iid)
  );

  // ------------------------------------------------------------------------
  // Pipe2
  // ------------------------------------------------------------------------
  // Flopped inside the branch unit, renamed only
  assign iu_rtu_pipe2_cmplt       = bju_cbus_ex2_pipe2_sel;
  assign iu_rtu_pipe2_iid         = bju_cbus_ex2_pipe2_iid;
  assign iu_rtu_pipe2_abnormal    = bju_cbus_ex2_pipe2_abnormal;
  assign iu_rtu_pipe2_jmp_mispred = bju_cbus_ex2_pipe2_jmp_mispred;
  assign iu_rtu_pipe2_bht_mispred = bju_cbus_ex2_pipe2_bht_mispred;

endmodule

`default_nettype wire

// ==== design/cbus_types_pkg.sv ====
/*
 * Payload types carried by the completion bus.
 * The pipe0 record is built by the source select, held by the stage
 * register and unpacked onto the retire ports by the top level.
 */
`default_nettype none

package cbus_types_pkg;

  import cbus_cfg_pkg::*;

  typedef logic [IID_W-1:0] iid_t;

  // ------------------------------------------------------------------------
  // Pipe0 completion record, 88 bits
  // ------------------------------------------------------------------------
  typedef struct packed {
    iid_t                  iid;
    logic                  abnormal;
    logic                  expt_vld;
    logic [EXPT_VEC_W-1:0] expt_vec;
    logic                  flush;
    // Only the special unit raises this
    logic                  bkpt;
    logic [MTVAL_W-1:0]    mtval;
    // Exception PC, system-register unit only
    logic                  efpc_vld;
    logic [EFPC_W-1:0]     efpc;
  } pipe0_cmplt_t;

endpackage

`default_nettype wire

// ==== flist.f ====
design/cbus_cfg_pkg.sv
design/cbus_types_pkg.sv
design/cbus_src_if.sv
design/cbus_pipe0_src_sel.sv
design/cbus_cmplt_stage.sv
design/cbus_top.sv
bench/cbus_chk.sv
bench/cbus_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the completion bus testbench with Verilator.
# Exit status is nonzero unless the log holds the pass line.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cbus_tb -f flist.f -o cbus_sim

# Let assertion errors accumulate so the testbench prints its summary
./obj_dir/cbus_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
